//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_list_ctrl
FILELIST  ?= list_ctrl.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- design/access_ctrl.sv
`timescale 1ns/1ns

module access_ctrl #(
    parameter int lists_depth = 4,
    parameter int index_width = 4
) (
    input  logic                           acc_req,
    input  logic [1:0]                     acc_cmd,
    input  logic [index_width-1:0]         acc_index,
    input  logic [$clog2(lists_depth)-1:0] acc_tag,
    input  logic                           match,
    input  logic [$clog2(lists_depth)-1:0] match_tag,
    input  logic [$clog2(lists_depth)-1:0] victim_tag,
    input  logic                           free_empty,
    input  logic [2:0]                     status_all [lists_depth],
    input  logic [2:0]                     rd_status,
    input  logic [index_width-1:0]         rd_index,
    output logic                           touch,
    output logic [$clog2(lists_depth)-1:0] touch_tag,
    output logic                           alloc,
    output logic [$clog2(lists_depth)-1:0] alloc_tag,
    output logic [index_width-1:0]         alloc_index,
    output logic                           write_hit,
    output logic [$clog2(lists_depth)-1:0] hit_tag,
    output logic                           fill,
    output logic [$clog2(lists_depth)-1:0] fill_tag,
    output logic [$clog2(lists_depth)-1:0] rd_tag,
    output logic [2:0]                     acc_status,
    output logic [$clog2(lists_depth)-1:0] return_tag,
    output logic [index_width-1:0]         return_index,
    output logic                           allocate_busy
);

    logic lookup;
    logic hit;
    logic answer;

    assign lookup = acc_req && (acc_cmd == list_ctrl_pkg::cmd_write ||
                                acc_cmd == list_ctrl_pkg::cmd_read);
    assign hit    = lookup && match;

    // only victim left is still waiting for its line
    assign allocate_busy = free_empty && status_all[victim_tag] == list_ctrl_pkg::st_fetch;

    assign alloc       = acc_req && acc_cmd == list_ctrl_pkg::cmd_alloc && !allocate_busy;
    assign alloc_tag   = victim_tag;
    assign alloc_index = acc_index;

    assign touch     = hit;
    assign touch_tag = match_tag;
    assign write_hit = hit && acc_cmd == list_ctrl_pkg::cmd_write;
    assign hit_tag   = match_tag;

    assign fill     = acc_req && acc_cmd == list_ctrl_pkg::cmd_fill;
    assign fill_tag = acc_tag;

    // old contents of the victim on allocate
    assign rd_tag = alloc ? victim_tag : match_tag;
    assign answer = hit || alloc;

    assign return_tag   = answer ? rd_tag : '0;
    assign acc_status   = answer ? rd_status : list_ctrl_pkg::st_invalid;
    assign return_index = answer ? rd_index : '0;

endmodule

//--- design/list_ctrl.sv
`timescale 1ns/1ns

module list_ctrl #(
    parameter int lists_depth = 4,
    parameter int index_width = 4
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           acc_req,
    input  logic [1:0]                     acc_cmd,
    input  logic [index_width-1:0]         acc_index,
    input  logic [$clog2(lists_depth)-1:0] acc_tag,
    output logic [2:0]                     acc_status,
    output logic [$clog2(lists_depth)-1:0] return_tag,
    output logic [index_width-1:0]         return_index,
    output logic                           allocate_busy
);

    localparam int tag_w = $clog2(lists_depth);

    logic [2:0]             status_all [lists_depth];
    logic [index_width-1:0] index_all [lists_depth];
    logic                   match;
    logic [tag_w-1:0]       match_tag;
    logic [tag_w-1:0]       victim_tag;
    logic                   free_empty;
    logic                   touch;
    logic [tag_w-1:0]       touch_tag;
    logic                   alloc;
    logic [tag_w-1:0]       alloc_tag;
    logic [index_width-1:0] alloc_index;
    logic                   write_hit;
    logic [tag_w-1:0]       hit_tag;
    logic                   fill;
    logic [tag_w-1:0]       fill_tag;
    logic [tag_w-1:0]       rd_tag;
    logic [2:0]             rd_status;
    logic [index_width-1:0] rd_index;

    tag_table #(
        .lists_depth(lists_depth),
        .index_width(index_width)
    ) u_tag_table (
        .clk        (clk),
        .rst_n      (rst_n),
        .alloc      (alloc),
        .alloc_tag  (alloc_tag),
        .alloc_index(alloc_index),
        .write_hit  (write_hit),
        .hit_tag    (hit_tag),
        .fill       (fill),
        .fill_tag   (fill_tag),
        .rd_tag     (rd_tag),
        .status_all (status_all),
        .index_all  (index_all),
        .rd_status  (rd_status),
        .rd_index   (rd_index)
    );

    tag_match #(
        .lists_depth(lists_depth),
        .index_width(index_width)
    ) u_tag_match (
        .acc_index (acc_index),
        .status_all(status_all),
        .index_all (index_all),
        .match     (match),
        .match_tag (match_tag)
    );

    lru_lists #(
        .lists_depth(lists_depth)
    ) u_lru_lists (
        .clk       (clk),
        .rst_n     (rst_n),
        .touch     (touch),
        .touch_tag (touch_tag),
        .alloc     (alloc),
        .victim_tag(victim_tag),
        .free_empty(free_empty)
    );

    access_ctrl #(
        .lists_depth(lists_depth),
        .index_width(index_width)
    ) u_access_ctrl (
        .acc_req      (acc_req),
        .acc_cmd      (acc_cmd),
        .acc_index    (acc_index),
        .acc_tag      (acc_tag),
        .match        (match),
        .match_tag    (match_tag),
        .victim_tag   (victim_tag),
        .free_empty   (free_empty),
        .status_all   (status_all),
        .rd_status    (rd_status),
        .rd_index     (rd_index),
        .touch        (touch),
        .touch_tag    (touch_tag),
        .alloc        (alloc),
        .alloc_tag    (alloc_tag),
        .alloc_index  (alloc_index),
        .write_hit    (write_hit),
        .hit_tag      (hit_tag),
        .fill         (fill),
        .fill_tag     (fill_tag),
        .rd_tag       (rd_tag),
        .acc_status   (acc_status),
        .return_tag   (return_tag),
        .return_index (return_index),
        .allocate_busy(allocate_busy)
    );

endmodule

//--- design/list_ctrl_pkg.sv
package list_ctrl_pkg;

    // access commands
    localparam logic [1:0] cmd_write = 2'b00;
    localparam logic [1:0] cmd_read  = 2'b01;
    localparam logic [1:0] cmd_alloc = 2'b10;
    // fill done, entry addressed by acc_tag
    localparam logic [1:0] cmd_fill  = 2'b11;

    // entry status, fetch sits apart in bit 2
    localparam logic [2:0] st_invalid = 3'b000;
    localparam logic [2:0] st_valid   = 3'b001;
    localparam logic [2:0] st_dirty   = 3'b010;
    localparam logic [2:0] st_fetch   = 3'b100;

endpackage

//--- design/lru_lists.sv
`timescale 1ns/1ns

module lru_lists #(
    parameter int lists_depth = 4
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           touch,
    input  logic [$clog2(lists_depth)-1:0] touch_tag,
    input  logic                           alloc,
    output logic [$clog2(lists_depth)-1:0] victim_tag,
    output logic                           free_empty
);

    localparam int tag_w = $clog2(lists_depth);
    localparam int len_w = tag_w + 1;

    logic [tag_w-1:0] pre [lists_depth];
    logic [tag_w-1:0] nxt [lists_depth];
    logic [tag_w-1:0] lru_head;
    logic [tag_w-1:0] lru_tail;
    logic [len_w-1:0] lru_len;
    logic [tag_w-1:0] free_head;
    logic [tag_w-1:0] free_tail;
    logic [len_w-1:0] free_len;

    logic             take_free;
    logic             move;
    logic [tag_w-1:0] move_tag;

    assign free_empty = (free_len == '0);
    assign victim_tag = free_empty ? lru_tail : free_tail;

    // eviction reuses the LRU tail, which is just a move of the tail to the head
    assign take_free = alloc && !free_empty;
    assign move      = touch || (alloc && free_empty);
    assign move_tag  = touch ? touch_tag : lru_tail;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // free list starts as a ring 0 .. lists_depth-1
            for (int i = 0; i < lists_depth; i++) begin
                pre[i] <= tag_w'((i + lists_depth - 1) % lists_depth);
                nxt[i] <= tag_w'((i + 1) % lists_depth);
            end
            lru_head  <= '0;
            lru_tail  <= '0;
            lru_len   <= '0;
            free_head <= '0;
            free_tail <= tag_w'(lists_depth - 1);
            free_len  <= len_w'(lists_depth);
        end else if (take_free) begin
            free_tail <= pre[free_tail];
            free_len  <= free_len - 1'b1;
            // close the free ring around the removed tail
            if (free_len > len_w'(1)) begin
                nxt[pre[free_tail]] <= free_head;
                pre[free_head]      <= pre[free_tail];
            end
            lru_head <= free_tail;
            lru_len  <= lru_len + 1'b1;
            if (lru_len == '0) begin
                lru_tail <= free_tail;
            end else begin
                nxt[free_tail] <= lru_head;
                pre[lru_head]  <= free_tail;
            end
        end else if (move && move_tag != lru_head) begin
            nxt[move_tag] <= lru_head;
            pre[lru_head] <= move_tag;
            lru_head      <= move_tag;
            if (move_tag == lru_tail) begin
                lru_tail <= pre[move_tag];
            end else begin
                // middle entry, bridge its neighbours
                nxt[pre[move_tag]] <= nxt[move_tag];
                pre[nxt[move_tag]] <= pre[move_tag];
            end
        end
    end

    // entries never leave both lists
    a_len_sum: assert property (
        @(posedge clk) disable iff (!rst_n)
        (free_len + lru_len) == lists_depth
    ) else $error("lru_lists: list lengths do not sum to depth");

    a_no_touch_alloc: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(touch && alloc)
    ) else $error("lru_lists: touch and alloc together");

    // a full free list leaves nothing that could have hit
    a_touch_live: assert property (
        @(posedge clk) disable iff (!rst_n)
        touch |-> (free_len != len_w'(lists_depth))
    ) else $error("lru_lists: touch while every entry is free");

endmodule

//--- design/tag_match.sv
`timescale 1ns/1ns

module tag_match #(
    parameter int lists_depth = 4,
    parameter int index_width = 4
) (
    input  logic [index_width-1:0]         acc_index,
    input  logic [2:0]                     status_all [lists_depth],
    input  logic [index_width-1:0]         index_all [lists_depth],
    output logic                           match,
    output logic [$clog2(lists_depth)-1:0] match_tag
);

    localparam int tag_w = $clog2(lists_depth);

    // later entries win, so the highest matching tag is reported
    always_comb begin
        match     = 1'b0;
        match_tag = '0;
        for (int i = 0; i < lists_depth; i++) begin
            if (status_all[i] != list_ctrl_pkg::st_invalid && index_all[i] == acc_index) begin
                match     = 1'b1;
                match_tag = tag_w'(i);
            end
        end
    end

endmodule

//--- design/tag_table.sv
`timescale 1ns/1ns

module tag_table #(
    parameter int lists_depth = 4,
    parameter int index_width = 4
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           alloc,
    input  logic [$clog2(lists_depth)-1:0] alloc_tag,
    input  logic [index_width-1:0]         alloc_index,
    input  logic                           write_hit,
    input  logic [$clog2(lists_depth)-1:0] hit_tag,
    input  logic                           fill,
    input  logic [$clog2(lists_depth)-1:0] fill_tag,
    input  logic [$clog2(lists_depth)-1:0] rd_tag,
    output logic [2:0]                     status_all [lists_depth],
    output logic [index_width-1:0]         index_all [lists_depth],
    output logic [2:0]                     rd_status,
    output logic [index_width-1:0]         rd_index
);

    localparam int tag_w = $clog2(lists_depth);

    for (genvar i = 0; i < lists_depth; i++) begin : g_entry
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                status_all[i] <= list_ctrl_pkg::st_invalid;
                index_all[i]  <= '0;
            end else if (alloc && alloc_tag == tag_w'(i)) begin
                // new line, wait for its fill
                status_all[i] <= list_ctrl_pkg::st_fetch;
                index_all[i]  <= alloc_index;
            end else if (write_hit && hit_tag == tag_w'(i)) begin
                // a line still in flight stays fetching
                if (status_all[i] != list_ctrl_pkg::st_fetch) begin
                    status_all[i] <= list_ctrl_pkg::st_dirty;
                end
            end else if (fill && fill_tag == tag_w'(i)) begin
                status_all[i] <= list_ctrl_pkg::st_valid;
            end
        end
    end

    // read port for responses
    assign rd_status = status_all[rd_tag];
    assign rd_index  = index_all[rd_tag];

    // one access port, so one strobe per cycle
    a_one_strobe: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0({alloc, write_hit, fill})
    ) else $error("tag_table: more than one update strobe");

endmodule

//--- list_ctrl.f
design/list_ctrl_pkg.sv
design/tag_match.sv
design/tag_table.sv
design/lru_lists.sv
design/access_ctrl.sv
design/list_ctrl.sv
tb/tb_list_ctrl.sv

//--- tb/tb_list_ctrl.sv
`timescale 1ns/1ns

module tb_list_ctrl;

    localparam int lists_depth = 4;
    localparam int index_width = 4;
    localparam int tag_w = $clog2(lists_depth);

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   acc_req;
    logic [1:0]             acc_cmd;
    logic [index_width-1:0] acc_index;
    logic [tag_w-1:0]       acc_tag;
    logic [2:0]             acc_status;
    logic [tag_w-1:0]       return_tag;
    logic [index_width-1:0] return_index;
    logic                   allocate_busy;

    // reference model, front of lru_q is the most recently used entry
    logic [2:0]             m_status [lists_depth];
    logic [index_width-1:0] m_index [lists_depth];
    int                     lru_q [$];
    int                     free_left;
    int                     last_tag;
    int                     last_status;
    int                     last_index;
    integer                 seed;

    list_ctrl #(.lists_depth(lists_depth), .index_width(index_width)) u_dut (.*);

    always #2 clk = ~clk;

    task automatic stop_on_error();
        $display("Some tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_eq(input string what, input int got, input int exp);
        assert (got == exp) else begin
            $display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    function automatic int find_tag(input int idx);
        int t = -1;
        for (int i = 0; i < lists_depth; i++) begin
            if (m_status[i] != list_ctrl_pkg::st_invalid && int'(m_index[i]) == idx) t = i;
        end
        return t;
    endfunction

    function automatic int fresh_index(input int start);
        int idx = start % (1 << index_width);
        while (find_tag(idx) >= 0) idx = (idx + 1) % (1 << index_width);
        return idx;
    endfunction

    task automatic move_to_head(input int t);
        int pos [$];
        pos = lru_q.find_first_index with (item == t);
        lru_q.delete(pos[0]);
        lru_q.push_front(t);
    endtask

    // drive one access, check the responses, then step the model with the edge
    task automatic do_access(input logic [1:0] cmd, input int idx, input int tag);
        int   hit_tag;
        int   vtag;
        logic busy;
        logic lookup;
        int   exp_tag;
        int   exp_status;
        int   exp_index;
        hit_tag    = find_tag(idx);
        busy       = free_left == 0 && m_status[lru_q[$]] == list_ctrl_pkg::st_fetch;
        vtag       = (free_left > 0) ? free_left - 1 : lru_q[$];
        lookup     = cmd == list_ctrl_pkg::cmd_read || cmd == list_ctrl_pkg::cmd_write;
        exp_tag    = 0;
        exp_status = int'(list_ctrl_pkg::st_invalid);
        exp_index  = 0;
        if (lookup && hit_tag >= 0) begin
            exp_tag    = hit_tag;
            exp_status = int'(m_status[hit_tag]);
            exp_index  = int'(m_index[hit_tag]);
        end else if (cmd == list_ctrl_pkg::cmd_alloc && !busy) begin
            exp_tag    = vtag;
            exp_status = int'(m_status[vtag]);
            exp_index  = int'(m_index[vtag]);
        end
        acc_req   = 1'b1;
        acc_cmd   = cmd;
        acc_index = idx[index_width-1:0];
        acc_tag   = tag[tag_w-1:0];
        #1;
        last_tag    = int'(return_tag);
        last_status = int'(acc_status);
        last_index  = int'(return_index);
        check_eq("allocate_busy", int'(allocate_busy), int'(busy));
        check_eq("return_tag", last_tag, exp_tag);
        check_eq("acc_status", last_status, exp_status);
        check_eq("return_index", last_index, exp_index);
        if (lookup && hit_tag >= 0) begin
            if (cmd == list_ctrl_pkg::cmd_write && m_status[hit_tag] != list_ctrl_pkg::st_fetch)
                m_status[hit_tag] = list_ctrl_pkg::st_dirty;
            move_to_head(hit_tag);
        end else if (cmd == list_ctrl_pkg::cmd_alloc && !busy) begin
            if (free_left > 0) begin
                free_left--;
                lru_q.push_front(vtag);
            end else begin
                move_to_head(vtag);
            end
            m_status[vtag] = list_ctrl_pkg::st_fetch;
            m_index[vtag]  = idx[index_width-1:0];
        end else if (cmd == list_ctrl_pkg::cmd_fill) begin
            m_status[tag] = list_ctrl_pkg::st_valid;
        end
        @(posedge clk);
        #1;
        acc_req = 1'b0;
    endtask

    task automatic wait_busy_clear(input int max_cycles);
        int n = 0;
        while (allocate_busy && n < max_cycles) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (allocate_busy) begin
            $display("timeout: allocate_busy still high after %0d cycles", max_cycles);
            stop_on_error();
        end
    endtask

    task automatic test_after_reset();
        check_eq("allocate_busy after reset", int'(allocate_busy), 0);
        for (int i = 0; i < (1 << index_width); i++) begin
            do_access(list_ctrl_pkg::cmd_read, i, 0);
            check_eq("status after reset", last_status, int'(list_ctrl_pkg::st_invalid));
        end
    endtask

    task automatic test_alloc_free();
        // index 3*i+1 goes to tag lists_depth-1-i
        for (int i = 0; i < lists_depth; i++) begin
            do_access(list_ctrl_pkg::cmd_alloc, 3 * i + 1, 0);
            check_eq("tag from free list", last_tag, lists_depth - 1 - i);
            check_eq("old status of free entry", last_status, int'(list_ctrl_pkg::st_invalid));
        end
        for (int t = 0; t < lists_depth; t++) begin
            do_access(list_ctrl_pkg::cmd_fill, 0, t);
            do_access(list_ctrl_pkg::cmd_read, 3 * (lists_depth - 1 - t) + 1, 0);
            check_eq("status after fill", last_status, int'(list_ctrl_pkg::st_valid));
            check_eq("index after fill", last_index, 3 * (lists_depth - 1 - t) + 1);
        end
    endtask

    task automatic test_write_hits();
        int idx;
        do_access(list_ctrl_pkg::cmd_write, 1, 0);
        do_access(list_ctrl_pkg::cmd_read, 1, 0);
        check_eq("write hit on valid", last_status, int'(list_ctrl_pkg::st_dirty));
        idx = fresh_index(0);
        do_access(list_ctrl_pkg::cmd_alloc, idx, 0);
        do_access(list_ctrl_pkg::cmd_write, idx, 0);
        do_access(list_ctrl_pkg::cmd_read, idx, 0);
        check_eq("write hit on fetching", last_status, int'(list_ctrl_pkg::st_fetch));
    endtask

    task automatic test_lru_evict();
        int d;
        int old_index;
        for (int t = 0; t < lists_depth; t++) do_access(list_ctrl_pkg::cmd_fill, 0, t);
        d = lru_q[0];
        old_index = int'(m_index[d]);
        do_access(list_ctrl_pkg::cmd_write, old_index, 0);
        // touch everything else so d drops to the tail
        for (int t = 0; t < lists_depth; t++) begin
            if (t != d) do_access(list_ctrl_pkg::cmd_read, int'(m_index[t]), 0);
        end
        do_access(list_ctrl_pkg::cmd_alloc, fresh_index(old_index + 1), 0);
        check_eq("victim tag", last_tag, d);
        check_eq("victim old status", last_status, int'(list_ctrl_pkg::st_dirty));
        check_eq("victim old index", last_index, old_index);
    endtask

    task automatic test_busy();
        int f;
        int idx;
        f = lru_q[0];
        for (int t = 0; t < lists_depth; t++) begin
            if (t != f) do_access(list_ctrl_pkg::cmd_read, int'(m_index[t]), 0);
        end
        check_eq("busy with fetching tail", int'(allocate_busy), 1);
        idx = fresh_index(0);
        do_access(list_ctrl_pkg::cmd_alloc, idx, 0);
        check_eq("refused allocate status", last_status, int'(list_ctrl_pkg::st_invalid));
        do_access(list_ctrl_pkg::cmd_read, idx, 0);
        check_eq("refused index absent", last_status, int'(list_ctrl_pkg::st_invalid));
        do_access(list_ctrl_pkg::cmd_read, int'(m_index[f]), 0);
        check_eq("fetching entry kept", last_status, int'(list_ctrl_pkg::st_fetch));
        check_eq("fetching entry tag", last_tag, f);
        do_access(list_ctrl_pkg::cmd_fill, 0, f);
        wait_busy_clear(8);
    endtask

    task automatic test_random();
        int sel;
        int idx;
        int t;
        seed = 69543;
        for (int n = 0; n < 200; n++) begin
            sel = $unsigned($random(seed)) % 4;
            t   = lru_q[$unsigned($random(seed)) % lru_q.size()];
            idx = $unsigned($random(seed)) % (1 << index_width);
            // odd steps use a random index, even ones a live entry
            case (sel)
                0: do_access(list_ctrl_pkg::cmd_write, (n % 2) ? idx : int'(m_index[t]), 0);
                1: do_access(list_ctrl_pkg::cmd_read, (n % 2) ? idx : int'(m_index[t]), 0);
                2: do_access(list_ctrl_pkg::cmd_alloc, fresh_index(idx), 0);
                default: do_access(list_ctrl_pkg::cmd_fill, 0, t);
            endcase
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        acc_req   = 1'b0;
        acc_cmd   = list_ctrl_pkg::cmd_read;
        acc_index = '0;
        acc_tag   = '0;
        free_left = lists_depth;
        for (int i = 0; i < lists_depth; i++) begin
            m_status[i] = list_ctrl_pkg::st_invalid;
            m_index[i]  = '0;
        end
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_after_reset();
        test_alloc_free();
        test_write_hits();
        test_lru_evict();
        test_busy();
        test_random();
        $display("All tests passed");
        $finish;
    end

    initial begin
        #50000;
        $display("timeout: the test sequence did not finish in time");
        stop_on_error();
    end

endmodule
